//--- hw/rtc_pkg.sv
// shared constants and enum types for the real-time clock block, imported by every rtc module
package rtc_pkg;

    // command bus decode
    localparam logic [10:0] rtc_addr = 11'h704;     // base of the 4-word command window
    localparam logic [10:0] rtc_mask = 11'h7fc;     // low two bits select the opcode

    // reference clock prescaler
    localparam int prediv_w = 5;                    // wide enough for rtc_mhz
    localparam logic [prediv_w-1:0] rtc_mhz = 5'd25; // refclk in MHz, edges per half usec

    // time limits
    localparam logic [19:0] usec_max = 20'd999999;  // last usec before seconds carry

    // status packet
    localparam logic [7:0] status_addr = 8'h31;     // first byte of each packet
    localparam int status_bytes = 9;                // addr, seq/alt, 4 sec, 3 usec

    // opcodes decoded from the unmasked address bits
    typedef enum logic [2:0] {
        set_usec   = 3'd0,                          // stage usec for next load
        set_sec    = 3'd1,                          // stage sec, enable, arm load
        set_corr   = 3'd2,                          // signed fine rate trim
        set_status = 3'd3                           // snapshot and status mode/seq
    } rtc_cmd_e;

    // command deserializer states, one per byte after AL
    typedef enum logic [2:0] {
        idle,                                       // waiting for cmd_stb with AL
        addr_hi,                                    // AH on the bus
        data0,                                      // D0, lsb
        data1,
        data2,
        data3                                       // D3, compare and issue we
    } deser_state_e;

    // status sender states
    typedef enum logic [1:0] {
        send_idle,                                  // ready for a snapshot
        send_wait,                                  // rq high until start
        send_bytes                                  // shifting payload bytes
    } send_state_e;

endpackage

//--- hw/rtc_snap_if.sv
// snapshot bundle passed from the timer core to the status packet sender
`timescale 1ns/1ns

interface rtc_snap_if;
    logic        snap_stb;   // one cycle, new snapshot valid
    logic [1:0]  snap_mode;  // 0 means no status packet
    logic [5:0]  snap_seq;   // caller sequence tag
    logic [31:0] snap_sec;   // captured seconds
    logic [19:0] snap_usec;  // captured microseconds
    logic        snap_alt;   // flips on every snapshot

    modport timer (
        output snap_stb, snap_mode, snap_seq,
        output snap_sec, snap_usec, snap_alt
    );

    modport sender (
        input snap_stb, snap_mode, snap_seq,
        input snap_sec, snap_usec, snap_alt
    );
endinterface

//--- hw/cmd_deser.sv
// byte-serial command receiver, turns the six-byte AL/AH/D0-D3 stream into one write pulse
`timescale 1ns/1ns

module cmd_deser import rtc_pkg::*; (
    input  logic        mclk,
    input  logic        rst,
    input  logic [7:0]  cmd_ad,   // AL AH D0 D1 D2 D3
    input  logic        cmd_stb,  // with AL only
    output rtc_cmd_e    opcode,
    output logic [31:0] data,
    output logic        we        // six cycles after cmd_stb
);

    deser_state_e state;
    logic [10:0]  addr_sr;        // {AH[2:0], AL}
    logic [23:0]  data_sr;        // D2 D1 D0
    logic         addr_hit;

    // match on the masked bits only
    assign addr_hit = ((addr_sr ^ rtc_addr) & rtc_mask) == 11'h000;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state <= idle;
            we    <= 1'b0;
        end else begin
            we <= 1'b0;                      // single pulse
            case (state)
                idle: begin
                    if (cmd_stb) state <= addr_hi;
                end
                addr_hi: state <= data0;
                data0:   state <= data1;
                data1:   state <= data2;
                data2:   state <= data3;
                data3: begin
                    we    <= addr_hit;       // silent on a miss
                    state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // address and data capture
    always_ff @(posedge mclk) begin
        case (state)
            idle: begin
                if (cmd_stb) addr_sr[7:0] <= cmd_ad;
            end
            addr_hi: addr_sr[10:8] <= cmd_ad[2:0];  // upper AH bits unused
            data0, data1, data2: begin
                data_sr <= {cmd_ad, data_sr[23:8]}; // lsb first
            end
            data3: begin
                data   <= {cmd_ad, data_sr};
                opcode <= rtc_cmd_e'(3'(addr_sr & ~rtc_mask)); // offset in window
            end
            default: ;
        endcase
    end

endmodule

//--- hw/rtc_timer.sv
// timer core, counts seconds and microseconds from refclk with a trimmed rate and takes snapshots
`timescale 1ns/1ns

module rtc_timer import rtc_pkg::*; (
    input  logic        mclk,
    input  logic        rst,
    input  logic        refclk,     // async, slower than mclk/2
    input  rtc_cmd_e    opcode,
    input  logic [31:0] data,
    input  logic        we,
    output logic [31:0] live_sec,
    output logic [19:0] live_usec,
    rtc_snap_if.timer   snap
);

    logic                wr_usec;
    logic                wr_sec;
    logic                wr_corr;
    logic                wr_status;
    logic [19:0]         wusec;       // staged usec
    logic [31:0]         wsec;        // staged sec
    logic [15:0]         corr;        // signed, 0x8000 is -1.0 of nominal
    logic [2:0]          ref_sync;    // refclk synchronizer
    logic                ref_edge;    // any refclk transition
    logic [prediv_w-1:0] pre_cntr;
    logic                tick;
    logic [3:0]          halfusec;    // one-hot running 0.5 us pipeline
    logic                enable_rtc;
    logic                pend_load;   // set_sec waiting for a boundary
    logic [24:0]         step;        // per half-usec increment
    logic [23:0]         acc;
    logic [24:0]         next_acc;
    logic                inc_usec;
    logic                usec_wrap;
    logic [19:0]         usec;
    logic [31:0]         sec;

    assign wr_usec   = we && (opcode == set_usec);
    assign wr_sec    = we && (opcode == set_sec);
    assign wr_corr   = we && (opcode == set_corr);
    assign wr_status = we && (opcode == set_status);

    assign tick     = enable_rtc && ref_edge && (pre_cntr == prediv_w'(1));
    assign next_acc = {1'b0, acc} + step;  // bit 24 is the usec carry

    assign live_sec  = sec;
    assign live_usec = usec;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            ref_sync   <= 3'b000;
            ref_edge   <= 1'b0;
            enable_rtc <= 1'b0;
            pend_load  <= 1'b0;
            pre_cntr   <= rtc_mhz;
            halfusec   <= 4'b0000;
            corr       <= 16'h0000;
            acc        <= 24'h000000;
            inc_usec   <= 1'b0;
            usec_wrap  <= 1'b0;
            usec       <= 20'h00000;
            sec        <= 32'h00000000;
        end else begin
            ref_sync <= {ref_sync[1:0], refclk};
            ref_edge <= ref_sync[2] ^ ref_sync[1]; // both edges count

            if (wr_corr) corr <= data[15:0];
            if (wr_sec)  enable_rtc <= 1'b1;       // stays on until reset

            // prescaler, 25 refclk edges per half usec
            if (!enable_rtc)   pre_cntr <= rtc_mhz;
            else if (ref_edge) pre_cntr <= tick ? rtc_mhz : pre_cntr - 1'b1;

            halfusec <= enable_rtc ? {halfusec[2:0], tick} : 4'b0000;

            if (wr_sec)           pend_load <= 1'b1;
            else if (halfusec[3]) pend_load <= 1'b0;

            // stage 1, accumulate and sample the wrap condition
            if (halfusec[1]) begin
                acc       <= next_acc[23:0];
                inc_usec  <= next_acc[24];
                usec_wrap <= (usec == usec_max);
            end

            // stage 3 load wins, stage 2 counts
            if (halfusec[3] && pend_load) begin
                usec <= wusec;
                sec  <= wsec;
                acc  <= 24'h000000;                // fresh phase after a set
            end else if (halfusec[2] && inc_usec) begin
                if (usec_wrap) begin
                    usec <= 20'h00000;
                    sec  <= sec + 1'b1;
                end else begin
                    usec <= usec + 1'b1;
                end
            end
        end
    end

    // stage 0, nominal half step 2^23 plus corr scaled to the same unit
    always_ff @(posedge mclk) begin
        if (halfusec[0]) step <= 25'h0800000 + {corr[15], corr, 8'h00};
    end

    // staged set values
    always_ff @(posedge mclk) begin
        if (wr_usec) wusec <= data[19:0];
        if (wr_sec)  wsec  <= data;
    end

    // snapshot strobe and alternating bit
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            snap.snap_stb <= 1'b0;
            snap.snap_alt <= 1'b0;
        end else begin
            snap.snap_stb <= wr_status;
            if (wr_status) snap.snap_alt <= ~snap.snap_alt;
        end
    end

    // snapshot payload, same edge as snap_stb
    always_ff @(posedge mclk) begin
        if (wr_status) begin
            snap.snap_sec  <= sec;
            snap.snap_usec <= usec;
            snap.snap_mode <= data[7:6];
            snap.snap_seq  <= data[5:0];
        end
    end

endmodule

//--- hw/status_sender.sv
// status packet sender, requests the bus for a snapshot and streams nine bytes after start
`timescale 1ns/1ns

module status_sender import rtc_pkg::*; (
    input  logic        mclk,
    input  logic        rst,
    input  logic        status_start,  // one cycle grant, address byte cycle
    output logic [7:0]  status_ad,
    output logic        status_rq,
    rtc_snap_if.sender  snap
);

    send_state_e state;
    logic [63:0] pkt;                  // remaining eight bytes, lsb byte next
    logic [3:0]  byte_cnt;             // bytes already sent incl address

    // address byte only in the start cycle, zero when nothing in flight
    assign status_ad = (state == send_bytes)                 ? pkt[7:0]    :
                       (state == send_wait && status_start)  ? status_addr :
                                                               8'h00;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state     <= send_idle;
            status_rq <= 1'b0;
            byte_cnt  <= 4'd0;
        end else begin
            case (state)
                send_idle: begin
                    if (snap.snap_stb && (snap.snap_mode != 2'b00)) begin
                        state     <= send_wait;
                        status_rq <= 1'b1;
                    end
                end
                send_wait: begin
                    if (status_start) begin
                        state     <= send_bytes;
                        status_rq <= 1'b0;  // drops right after start
                        byte_cnt  <= 4'd1;
                    end
                end
                send_bytes: begin
                    if (byte_cnt == 4'(status_bytes - 1)) begin
                        state <= send_idle; // last usec byte out
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                default: state <= send_idle;
            endcase
        end
    end

    // latch in idle only, later snapshots are dropped until done
    always_ff @(posedge mclk) begin
        if (state == send_idle && snap.snap_stb) begin
            pkt <= {4'h0, snap.snap_usec,          // 3 usec bytes, top nibble 0
                    snap.snap_sec,                 // 4 sec bytes
                    snap.snap_seq, 1'b0, snap.snap_alt};
        end else if (state == send_bytes) begin
            pkt <= {8'h00, pkt[63:8]};
        end
    end

endmodule

//--- hw/rtc_top.sv
// top of the real-time clock block, wires command receiver, timer core and status sender
`timescale 1ns/1ns

module rtc_top import rtc_pkg::*; (
    input  logic        mclk,
    input  logic        rst,
    input  logic        refclk,        // reference, < mclk/2
    input  logic [7:0]  cmd_ad,
    input  logic        cmd_stb,
    input  logic        status_start,
    output logic [7:0]  status_ad,
    output logic        status_rq,
    output logic [31:0] live_sec,
    output logic [19:0] live_usec
);

    rtc_cmd_e    cmd_opcode;
    logic [31:0] cmd_data;
    logic        cmd_we;

    rtc_snap_if snap_if_i ();          // timer to sender

    cmd_deser cmd_deser_i (
        .mclk    (mclk),
        .rst     (rst),
        .cmd_ad  (cmd_ad),
        .cmd_stb (cmd_stb),
        .opcode  (cmd_opcode),
        .data    (cmd_data),
        .we      (cmd_we)
    );

    rtc_timer rtc_timer_i (
        .mclk      (mclk),
        .rst       (rst),
        .refclk    (refclk),
        .opcode    (cmd_opcode),
        .data      (cmd_data),
        .we        (cmd_we),
        .live_sec  (live_sec),
        .live_usec (live_usec),
        .snap      (snap_if_i.timer)
    );

    status_sender status_sender_i (
        .mclk         (mclk),
        .rst          (rst),
        .status_start (status_start),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .snap         (snap_if_i.sender)
    );

endmodule

//--- dv/rtc_assertions.sv
// concurrent protocol checks for rtc_top, attached to every rtc_top instance by the bind below
`timescale 1ns/1ns

module rtc_assertions import rtc_pkg::*; (
    input logic        mclk,
    input logic        rst,
    input logic        status_rq,
    input logic        status_start,
    input logic [19:0] live_usec,
    input logic        cmd_we,
    input rtc_cmd_e    cmd_opcode
);

    logic seen_status;                         // any set_status since reset

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            seen_status <= 1'b0;
        end else if (cmd_we && cmd_opcode == set_status) begin
            seen_status <= 1'b1;
        end
    end

    rq_quiet_until_snapshot: assert property (@(posedge mclk) (rst || !seen_status) |-> !status_rq)
        else $error("status_rq high before any snapshot");

    rq_drops_after_start: assert property (@(posedge mclk) disable iff (rst)
        (status_rq && status_start) |=> !status_rq)
        else $error("status_rq still high after status_start");

    usec_in_range: assert property (@(posedge mclk) disable iff (rst) live_usec <= usec_max)
        else $error("live_usec above usec_max");

    we_single_cycle: assert property (@(posedge mclk) disable iff (rst) cmd_we |=> !cmd_we)
        else $error("cmd_we high for two cycles");

endmodule

bind rtc_top rtc_assertions rtc_assertions_i (
    .mclk         (mclk),
    .rst          (rst),
    .status_rq    (status_rq),
    .status_start (status_start),
    .live_usec    (live_usec),
    .cmd_we       (cmd_we),
    .cmd_opcode   (cmd_opcode)
);

//--- dv/rtc_tb.sv
// directed testbench for rtc_top, drives byte commands, answers status requests and checks time
`timescale 1ns/1ns

module rtc_tb import rtc_pkg::*; ();

    logic        mclk;
    logic        rst;
    logic        refclk;
    logic [7:0]  cmd_ad;
    logic        cmd_stb;
    logic        status_start;
    logic [7:0]  status_ad;
    logic        status_rq;
    logic [31:0] live_sec;
    logic [19:0] live_usec;

    int          err_cnt;
    int          to_cnt;
    integer      seed;
    logic        exp_alt;                      // model of snap_alt
    logic [7:0]  pkt [status_bytes];           // last collected packet

    rtc_top dut_i (
        .mclk         (mclk),
        .rst          (rst),
        .refclk       (refclk),
        .cmd_ad       (cmd_ad),
        .cmd_stb      (cmd_stb),
        .status_start (status_start),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .live_sec     (live_sec),
        .live_usec    (live_usec)
    );

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;               // 250 MHz
    end

    initial begin
        refclk = 1'b0;
        forever #20 refclk = ~refclk;          // 25 MHz reference
    end

    task automatic check_sec(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("** Error at %0t ns: %s expected 0x%08h actual 0x%08h",
                     $time, name, exp, act);
        end
    endtask

    task automatic check_usec(input string name, input logic [19:0] lo, input logic [19:0] hi,
                              input logic [19:0] act);
        if ((^act === 1'bx) || act < lo || act > hi) begin
            err_cnt++;
            $display("** Error at %0t ns: %s expected %0d..%0d actual %0d",
                     $time, name, lo, hi, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("** Error at %0t ns: %s expected 0x%02h actual 0x%02h",
                     $time, name, exp, act);
        end
    endtask

    // AL with strobe, then AH and D0..D3 lsb first
    task automatic send_cmd(input logic [10:0] addr, input logic [31:0] data);
        @(posedge mclk);
        cmd_stb <= 1'b1;
        cmd_ad  <= addr[7:0];
        @(posedge mclk);
        cmd_stb <= 1'b0;
        cmd_ad  <= {5'b00000, addr[10:8]};
        for (int i = 0; i < 4; i++) begin
            @(posedge mclk);
            cmd_ad <= data[8*i +: 8];
        end
        @(posedge mclk);
        cmd_ad <= 8'h00;
        repeat (3) @(posedge mclk);            // we and snapshot done
    endtask

    task automatic write_reg(input rtc_cmd_e op, input logic [31:0] data);
        send_cmd(rtc_addr | {8'h00, op}, data);
    endtask

    task automatic wait_sec(input logic [31:0] exp, input int limit);
        int n;
        n = 0;
        @(negedge mclk);
        while (live_sec !== exp && n < limit) begin
            @(negedge mclk);
            n++;
        end
        if (live_sec !== exp) begin
            to_cnt++;
            $display("Timeout: live_sec did not reach 0x%08h within %0d cycles", exp, limit);
        end
    endtask

    task automatic set_time(input logic [31:0] sec, input logic [19:0] usec);
        write_reg(set_usec, {12'h000, usec});
        write_reg(set_sec, sec);
        wait_sec(sec, 1000);                   // load at next half usec
    endtask

    // usec advance over 25 us of mclk
    task automatic measure_rate(output logic [19:0] delta);
        logic [19:0] u0;
        @(negedge mclk);
        u0 = live_usec;
        repeat (6250) @(negedge mclk);
        delta = live_usec - u0;
    endtask

    task automatic get_packet();
        int n;
        n = 0;
        for (int i = 0; i < status_bytes; i++) pkt[i] = 8'h00;
        @(negedge mclk);
        while (!status_rq && n < 200) begin
            @(negedge mclk);
            n++;
        end
        if (!status_rq) begin
            to_cnt++;
            $display("Timeout: no status_rq within 200 cycles of a snapshot");
        end else begin
            @(posedge mclk);
            status_start <= 1'b1;              // one cycle grant
            @(negedge mclk);
            pkt[0] = status_ad;                // address byte with start
            @(posedge mclk);
            status_start <= 1'b0;
            for (int i = 1; i < status_bytes; i++) begin
                @(negedge mclk);
                pkt[i] = status_ad;
                @(posedge mclk);
            end
            @(negedge mclk);
            check_byte("status_ad idle", 8'h00, status_ad);
        end
    endtask

    task automatic take_snapshot(input logic [5:0] seq);
        logic [31:0] s0;
        logic [31:0] s1;
        logic [31:0] psec;
        logic [19:0] u0;
        logic [19:0] u1;
        logic [19:0] pusec;
        @(negedge mclk);
        s0 = live_sec;
        u0 = live_usec;
        write_reg(set_status, {24'h000000, 2'b01, seq});
        exp_alt = ~exp_alt;
        @(negedge mclk);
        s1 = live_sec;
        u1 = live_usec;
        get_packet();
        psec  = {pkt[5], pkt[4], pkt[3], pkt[2]};
        pusec = {pkt[8][3:0], pkt[7], pkt[6]};
        check_byte("status addr byte", status_addr, pkt[0]);
        check_byte("seq/alt byte", {seq, 1'b0, exp_alt}, pkt[1]);
        check_byte("usec byte 2 top nibble", 8'h00, pkt[8] & 8'hf0);
        if (s0 == s1) begin
            check_sec("packet sec", s0, psec);
            check_usec("packet usec", u0, u1, pusec);
        end else if (psec == s0) begin
            check_usec("packet usec", u0, usec_max, pusec);   // taken before the wrap
        end else begin
            check_sec("packet sec", s1, psec);
            check_usec("packet usec", 20'd0, u1, pusec);
        end
    endtask

    task automatic reset_values_idle();
        @(negedge mclk);
        check_sec("live_sec after reset", 32'h00000000, live_sec);
        check_usec("live_usec after reset", 20'd0, 20'd0, live_usec);
        check_byte("status_ad after reset", 8'h00, status_ad);
    endtask

    task automatic set_time_random();
        logic [31:0] s;
        logic [19:0] u;
        s = $random(seed);
        u = 20'({$random(seed)} % 999000);
        set_time(s, u);
        check_sec("live_sec", s, live_sec);
        check_usec("live_usec", u, u + 20'd2, live_usec);
    endtask

    task automatic nominal_rate();
        logic [19:0] d;
        write_reg(set_corr, 32'h00000000);
        set_time(32'h00000100, 20'd1000);
        measure_rate(d);
        check_usec("usec delta at corr 0", 20'd24, 20'd26, d);
    endtask

    task automatic correction_rate();
        logic [19:0] d;
        write_reg(set_corr, 32'h00004000);     // +0.5 of nominal
        set_time(32'h00000200, 20'd1000);
        measure_rate(d);
        check_usec("usec delta at corr 0x4000", 20'd36, 20'd38, d);
        write_reg(set_corr, 32'h00000000);
    endtask

    task automatic usec_rollover();
        logic [31:0] s;
        int n;
        s = $random(seed);
        n = 0;
        set_time(s, 20'd999990);
        @(negedge mclk);
        while (live_usec >= 20'd100 && n < 10000) begin
            @(negedge mclk);
            n++;
        end
        if (live_usec >= 20'd100) begin
            to_cnt++;
            $display("Timeout: live_usec did not wrap within 10000 cycles");
        end
        check_sec("live_sec after wrap", s + 32'd1, live_sec);
    endtask

    // alt in each packet is checked against the toggling model
    task automatic snapshot_packets();
        logic [5:0] seq;
        seq = 6'($random(seed));
        take_snapshot(seq);
        take_snapshot(seq + 6'd1);
    endtask

    task automatic miss_and_silent();
        logic [19:0] d;
        int          n;
        set_time(32'h00000300, 20'd1000);
        send_cmd(11'h708, 32'h00000000);       // outside the window
        send_cmd(11'h709, 32'h00000305);
        send_cmd(11'h70a, 32'h00004000);       // corr slot one window up
        measure_rate(d);
        check_usec("usec delta after miss", 20'd24, 20'd26, d);
        check_sec("live_sec after miss", 32'h00000300, live_sec);
        write_reg(set_status, {24'h000000, 2'b00, 6'h2a});    // mode 0
        exp_alt = ~exp_alt;
        n = 0;
        @(negedge mclk);
        while (!status_rq && n < 500) begin
            @(negedge mclk);
            n++;
        end
        if (status_rq) begin
            err_cnt++;
            $display("status_rq was raised for a mode 0 snapshot");
        end
        take_snapshot(6'h15);                  // alt still follows the silent one
    endtask

    initial begin
        seed         = 13;
        err_cnt      = 0;
        to_cnt       = 0;
        exp_alt      = 1'b0;
        rst          = 1'b1;
        cmd_ad       = 8'h00;
        cmd_stb      = 1'b0;
        status_start = 1'b0;
        repeat (5) @(posedge mclk);
        rst <= 1'b0;
        repeat (5) @(posedge mclk);

        reset_values_idle();
        set_time_random();
        nominal_rate();
        correction_rate();
        usec_rollover();
        snapshot_packets();
        miss_and_silent();

        $display("errors %0d, timeouts %0d", err_cnt, to_cnt);
        if (err_cnt == 0 && to_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tb.f
hw/rtc_pkg.sv
hw/rtc_snap_if.sv
hw/cmd_deser.sv
hw/rtc_timer.sv
hw/status_sender.sv
hw/rtc_top.sv
dv/rtc_assertions.sv
dv/rtc_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

# build the testbench with timing and assertions enabled
verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module rtc_tb \
    -Mdir build -o rtc_sim

# the log decides the verdict
./build/rtc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
exit 1
